//--- xform_cfg.svh
`ifndef XFORM_CFG_SVH
`define XFORM_CFG_SVH

// Q16.16 fixed point
`define XF_FRAC_BITS   16
`define XF_WORD_W      32

// transform table
`define XF_TABLE_DEPTH 8
`define XF_ID_W        3

`endif

//--- geom_pkg.sv
`include "xform_cfg.svh"

package geom_pkg;

    typedef logic signed [`XF_WORD_W-1:0] fixed_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } pos_t;

    typedef struct packed {
        pos_t        pos;
        logic [23:0] color;  // rgb, passed through
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        fixed_t r11, r12, r13;
        fixed_t r21, r22, r23;
        fixed_t r31, r32, r33;
    } matrix_t;

    // ----------------------------------------
    // fixed-point helpers, wrap on overflow

    function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
        logic signed [2*`XF_WORD_W-1:0] prod;
        prod = a * b;
        return prod[`XF_FRAC_BITS +: `XF_WORD_W];  // floor of the product
    endfunction

    function automatic fixed_t fx_dot3(fixed_t a, fixed_t b, fixed_t c, pos_t p);
        return fx_mul(a, p.x) + fx_mul(b, p.y) + fx_mul(c, p.z);
    endfunction

    function automatic pos_t fx_rotate(matrix_t m, pos_t p);
        pos_t r;
        r.x = fx_dot3(m.r11, m.r12, m.r13, p);
        r.y = fx_dot3(m.r21, m.r22, m.r23, p);
        r.z = fx_dot3(m.r31, m.r32, m.r33, p);
        return r;
    endfunction

endpackage

//--- xform_pkg.sv
`include "xform_cfg.svh"

package xform_pkg;

    // camera records reuse this layout, scale unused
    typedef struct packed {
        geom_pkg::pos_t    scale;
        geom_pkg::matrix_t rot;
        geom_pkg::pos_t    pos;
    } xform_t;

    typedef struct packed {
        geom_pkg::triangle_t  triangle;
        xform_t               model;
        logic [`XF_ID_W-1:0]  camera_id;
    } model_world_t;

    // one vertex moving through a transform pipeline
    typedef struct packed {
        geom_pkg::vertex_t vtx;
        logic [1:0]        idx;
        logic              valid;
    } vert_stage_t;

    typedef enum logic [1:0] {user_host, user_model, user_camera} table_user_e;

    typedef enum logic [1:0] {st_idle, st_fetch, st_process, st_done} stage_state_e;

endpackage

//--- transform_table.sv
`timescale 1ns/1ps
`include "xform_cfg.svh"

module transform_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  logic [`XF_ID_W-1:0] waddr,
    input  xform_pkg::xform_t   wdata,
    input  logic [`XF_ID_W-1:0] raddr,
    input  logic                re,
    output xform_pkg::xform_t   rdata
);

    xform_pkg::xform_t mem [`XF_TABLE_DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `XF_TABLE_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) mem[waddr] <= wdata;
            if (re) rdata <= mem[raddr];  // one cycle read
        end
    end

endmodule

//--- xform_table_arbiter.sv
`timescale 1ns/1ps
`include "xform_cfg.svh"

module xform_table_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                host_we,
    input  logic [`XF_ID_W-1:0] host_addr,
    input  xform_pkg::xform_t   host_wdata,
    input  logic                model_req,
    input  logic [`XF_ID_W-1:0] model_addr,
    output logic                model_gnt,
    output logic                model_rvalid,
    input  logic                cam_req,
    input  logic [`XF_ID_W-1:0] cam_addr,
    output logic                cam_gnt,
    output logic                cam_rvalid,
    output logic                tbl_we,
    output logic [`XF_ID_W-1:0] tbl_waddr,
    output xform_pkg::xform_t   tbl_wdata,
    output logic                tbl_re,
    output logic [`XF_ID_W-1:0] tbl_raddr
);

    xform_pkg::table_user_e last_user;  // last reader served

    // host always first, readers alternate on a tie
    always_comb begin
        model_gnt = 1'b0;
        cam_gnt   = 1'b0;
        if (!host_we) begin
            if (model_req && cam_req) begin
                if (last_user == xform_pkg::user_model) cam_gnt = 1'b1;
                else model_gnt = 1'b1;
            end else begin
                model_gnt = model_req;
                cam_gnt   = cam_req;
            end
        end
    end

    assign tbl_we    = host_we;
    assign tbl_waddr = host_addr;
    assign tbl_wdata = host_wdata;
    assign tbl_re    = model_gnt | cam_gnt;
    assign tbl_raddr = cam_gnt ? cam_addr : model_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_user    <= xform_pkg::user_host;  // no reader yet
            model_rvalid <= 1'b0;
            cam_rvalid   <= 1'b0;
        end else begin
            model_rvalid <= model_gnt;  // data lands next cycle
            cam_rvalid   <= cam_gnt;
            if (model_gnt) last_user <= xform_pkg::user_model;
            else if (cam_gnt) last_user <= xform_pkg::user_camera;
        end
    end

endmodule

//--- model_fetch.sv
`timescale 1ns/1ps
`include "xform_cfg.svh"

module model_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  geom_pkg::triangle_t       tri_in,
    input  logic [`XF_ID_W-1:0]       model_id,
    input  logic [`XF_ID_W-1:0]       camera_id,
    input  logic                      in_valid,
    output logic                      in_ready,
    output logic                      req,
    output logic [`XF_ID_W-1:0]       addr,
    input  logic                      gnt,
    input  logic                      rvalid,
    input  xform_pkg::xform_t         rdata,
    output xform_pkg::model_world_t   token,
    output logic                      out_valid,
    input  logic                      out_ready
);

    xform_pkg::stage_state_e state;
    xform_pkg::model_world_t tok_r;
    logic [`XF_ID_W-1:0]     id_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= xform_pkg::st_idle;
        end else begin
            case (state)
                xform_pkg::st_idle:    if (in_valid) state <= xform_pkg::st_fetch;
                xform_pkg::st_fetch:   if (gnt) state <= xform_pkg::st_process;
                xform_pkg::st_process: if (rvalid) state <= xform_pkg::st_done;
                xform_pkg::st_done:    if (out_ready) state <= xform_pkg::st_idle;
                default:               state <= xform_pkg::st_idle;
            endcase
        end
    end

    // token payload
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            tok_r.triangle  <= tri_in;
            tok_r.camera_id <= camera_id;
            id_r            <= model_id;
        end
        if (state == xform_pkg::st_process && rvalid) tok_r.model <= rdata;
    end

    assign in_ready  = (state == xform_pkg::st_idle);
    assign req       = (state == xform_pkg::st_fetch);
    assign addr      = id_r;
    assign token     = tok_r;
    assign out_valid = (state == xform_pkg::st_done);

endmodule

//--- model_world_transformer.sv
`timescale 1ns/1ps
`include "xform_cfg.svh"

module model_world_transformer (
    input  logic                    clk,
    input  logic                    rst,
    input  xform_pkg::model_world_t model_world,
    input  logic                    in_valid,
    output logic                    in_ready,
    output geom_pkg::triangle_t     out_tri,
    output logic [`XF_ID_W-1:0]     out_camera_id,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    busy
);

    xform_pkg::stage_state_e state;
    xform_pkg::model_world_t mw_r;
    geom_pkg::triangle_t     tri_acc;
    logic [1:0]              vertex_idx;
    logic                    last_vertex_done;

    xform_pkg::vert_stage_t cur;
    xform_pkg::vert_stage_t scaled;
    xform_pkg::vert_stage_t rotated;
    xform_pkg::vert_stage_t translated;

    // ----------------------------------------
    // control

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= xform_pkg::st_idle;
            vertex_idx <= 2'd0;
        end else begin
            case (state)
                xform_pkg::st_idle: begin
                    if (in_valid) begin
                        vertex_idx <= 2'd0;
                        state      <= xform_pkg::st_process;
                    end
                end
                xform_pkg::st_process: begin
                    if (vertex_idx != 2'd3) vertex_idx <= vertex_idx + 2'd1;
                    if (last_vertex_done) state <= xform_pkg::st_done;
                end
                xform_pkg::st_done: begin
                    if (out_ready) state <= xform_pkg::st_idle;
                end
                default: state <= xform_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) mw_r <= model_world;
    end

    // one vertex per cycle into the pipe
    always_comb begin
        cur = '0;
        if (state == xform_pkg::st_process && vertex_idx != 2'd3) begin
            case (vertex_idx)
                2'd0:    cur.vtx = mw_r.triangle.v0;
                2'd1:    cur.vtx = mw_r.triangle.v1;
                default: cur.vtx = mw_r.triangle.v2;
            endcase
            cur.idx   = vertex_idx;
            cur.valid = 1'b1;
        end
    end

    // ----------------------------------------
    // scale, rotate, translate

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scaled     <= '0;
            rotated    <= '0;
            translated <= '0;
        end else begin
            scaled.vtx.pos.x <= geom_pkg::fx_mul(cur.vtx.pos.x, mw_r.model.scale.x);
            scaled.vtx.pos.y <= geom_pkg::fx_mul(cur.vtx.pos.y, mw_r.model.scale.y);
            scaled.vtx.pos.z <= geom_pkg::fx_mul(cur.vtx.pos.z, mw_r.model.scale.z);
            scaled.vtx.color <= cur.vtx.color;
            scaled.idx       <= cur.idx;
            scaled.valid     <= cur.valid;

            rotated.vtx.pos   <= geom_pkg::fx_rotate(mw_r.model.rot, scaled.vtx.pos);
            rotated.vtx.color <= scaled.vtx.color;
            rotated.idx       <= scaled.idx;
            rotated.valid     <= scaled.valid;

            translated.vtx.pos.x <= rotated.vtx.pos.x + mw_r.model.pos.x;
            translated.vtx.pos.y <= rotated.vtx.pos.y + mw_r.model.pos.y;
            translated.vtx.pos.z <= rotated.vtx.pos.z + mw_r.model.pos.z;
            translated.vtx.color <= rotated.vtx.color;
            translated.idx       <= rotated.idx;
            translated.valid     <= rotated.valid;
        end
    end

    // accumulator, one slot per vertex
    always_ff @(posedge clk) begin
        if (translated.valid) begin
            case (translated.idx)
                2'd0:    tri_acc.v0 <= translated.vtx;
                2'd1:    tri_acc.v1 <= translated.vtx;
                default: tri_acc.v2 <= translated.vtx;
            endcase
        end
    end

    assign last_vertex_done = translated.valid && (translated.idx == 2'd2);

    assign out_tri       = tri_acc;
    assign out_camera_id = mw_r.camera_id;
    assign in_ready      = (state == xform_pkg::st_idle);
    assign out_valid     = (state == xform_pkg::st_done);
    assign busy          = (state != xform_pkg::st_idle);

endmodule

//--- world_camera_transformer.sv
`timescale 1ns/1ps
`include "xform_cfg.svh"

module world_camera_transformer (
    input  logic                clk,
    input  logic                rst,
    input  geom_pkg::triangle_t in_tri,
    input  logic [`XF_ID_W-1:0] camera_id,
    input  logic                in_valid,
    output logic                in_ready,
    output logic                req,
    output logic [`XF_ID_W-1:0] addr,
    input  logic                gnt,
    input  logic                rvalid,
    input  xform_pkg::xform_t   rdata,
    output geom_pkg::triangle_t out_tri,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                busy
);

    xform_pkg::stage_state_e state;
    geom_pkg::triangle_t     tri_r;
    geom_pkg::triangle_t     tri_acc;
    xform_pkg::xform_t       cam_r;  // view matrix and camera position
    logic [`XF_ID_W-1:0]     cam_id_r;
    logic                    req_r;
    logic [1:0]              vertex_idx;
    logic                    last_vertex_done;

    xform_pkg::vert_stage_t cur;
    xform_pkg::vert_stage_t shifted;
    xform_pkg::vert_stage_t rotated;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= xform_pkg::st_idle;
            req_r      <= 1'b0;
            vertex_idx <= 2'd0;
        end else begin
            case (state)
                xform_pkg::st_idle: begin
                    if (in_valid) begin
                        req_r <= 1'b1;
                        state <= xform_pkg::st_fetch;
                    end
                end
                xform_pkg::st_fetch: begin
                    if (gnt) req_r <= 1'b0;  // hold until granted
                    if (rvalid) begin
                        vertex_idx <= 2'd0;
                        state      <= xform_pkg::st_process;
                    end
                end
                xform_pkg::st_process: begin
                    if (vertex_idx != 2'd3) vertex_idx <= vertex_idx + 2'd1;
                    if (last_vertex_done) state <= xform_pkg::st_done;
                end
                xform_pkg::st_done: begin
                    if (out_ready) state <= xform_pkg::st_idle;
                end
                default: state <= xform_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            tri_r    <= in_tri;
            cam_id_r <= camera_id;
        end
        if (state == xform_pkg::st_fetch && rvalid) cam_r <= rdata;
    end

    always_comb begin
        cur = '0;
        if (state == xform_pkg::st_process && vertex_idx != 2'd3) begin
            case (vertex_idx)
                2'd0:    cur.vtx = tri_r.v0;
                2'd1:    cur.vtx = tri_r.v1;
                default: cur.vtx = tri_r.v2;
            endcase
            cur.idx   = vertex_idx;
            cur.valid = 1'b1;
        end
    end

    // ----------------------------------------
    // subtract camera position, then view rotate

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shifted <= '0;
            rotated <= '0;
        end else begin
            shifted.vtx.pos.x <= cur.vtx.pos.x - cam_r.pos.x;
            shifted.vtx.pos.y <= cur.vtx.pos.y - cam_r.pos.y;
            shifted.vtx.pos.z <= cur.vtx.pos.z - cam_r.pos.z;
            shifted.vtx.color <= cur.vtx.color;
            shifted.idx       <= cur.idx;
            shifted.valid     <= cur.valid;

            rotated.vtx.pos   <= geom_pkg::fx_rotate(cam_r.rot, shifted.vtx.pos);
            rotated.vtx.color <= shifted.vtx.color;
            rotated.idx       <= shifted.idx;
            rotated.valid     <= shifted.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rotated.valid) begin
            case (rotated.idx)
                2'd0:    tri_acc.v0 <= rotated.vtx;
                2'd1:    tri_acc.v1 <= rotated.vtx;
                default: tri_acc.v2 <= rotated.vtx;
            endcase
        end
    end

    assign last_vertex_done = rotated.valid && (rotated.idx == 2'd2);

    assign req       = req_r;
    assign addr      = cam_id_r;
    assign out_tri   = tri_acc;
    assign in_ready  = (state == xform_pkg::st_idle);
    assign out_valid = (state == xform_pkg::st_done);
    assign busy      = (state != xform_pkg::st_idle);

endmodule

//--- geometry_front.sv
`timescale 1ns/1ps
`include "xform_cfg.svh"

module geometry_front (
    input  logic                clk,
    input  logic                rst,
    input  logic                tbl_we,
    input  logic [`XF_ID_W-1:0] tbl_addr,
    input  xform_pkg::xform_t   tbl_wdata,
    input  geom_pkg::triangle_t tri_in,
    input  logic [`XF_ID_W-1:0] model_id,
    input  logic [`XF_ID_W-1:0] camera_id,
    input  logic                in_valid,
    output logic                in_ready,
    output geom_pkg::triangle_t tri_out,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                busy
);

    // table side
    logic                we;
    logic [`XF_ID_W-1:0] waddr;
    xform_pkg::xform_t   wdata;
    logic                re;
    logic [`XF_ID_W-1:0] raddr;
    xform_pkg::xform_t   rdata;

    // readers
    logic                mf_req, mf_gnt, mf_rvalid;
    logic [`XF_ID_W-1:0] mf_addr;
    logic                wc_req, wc_gnt, wc_rvalid;
    logic [`XF_ID_W-1:0] wc_addr;

    // hops between units
    xform_pkg::model_world_t token;
    logic                    token_valid, token_ready;
    geom_pkg::triangle_t     world_tri;
    logic [`XF_ID_W-1:0]     world_cam_id;
    logic                    world_valid, world_ready;
    logic                    mw_busy, wc_busy;

    transform_table u_table (
        .clk, .rst, .we, .waddr, .wdata, .raddr, .re, .rdata
    );

    xform_table_arbiter u_arb (
        .clk, .rst,
        .host_we(tbl_we), .host_addr(tbl_addr), .host_wdata(tbl_wdata),
        .model_req(mf_req), .model_addr(mf_addr),
        .model_gnt(mf_gnt), .model_rvalid(mf_rvalid),
        .cam_req(wc_req), .cam_addr(wc_addr),
        .cam_gnt(wc_gnt), .cam_rvalid(wc_rvalid),
        .tbl_we(we), .tbl_waddr(waddr), .tbl_wdata(wdata),
        .tbl_re(re), .tbl_raddr(raddr)
    );

    model_fetch u_fetch (
        .clk, .rst, .tri_in, .model_id, .camera_id, .in_valid, .in_ready,
        .req(mf_req), .addr(mf_addr), .gnt(mf_gnt), .rvalid(mf_rvalid), .rdata,
        .token, .out_valid(token_valid), .out_ready(token_ready)
    );

    model_world_transformer u_mw (
        .clk, .rst, .model_world(token), .in_valid(token_valid), .in_ready(token_ready),
        .out_tri(world_tri), .out_camera_id(world_cam_id),
        .out_valid(world_valid), .out_ready(world_ready), .busy(mw_busy)
    );

    world_camera_transformer u_wc (
        .clk, .rst, .in_tri(world_tri), .camera_id(world_cam_id),
        .in_valid(world_valid), .in_ready(world_ready),
        .req(wc_req), .addr(wc_addr), .gnt(wc_gnt), .rvalid(wc_rvalid), .rdata,
        .out_tri(tri_out), .out_valid, .out_ready, .busy(wc_busy)
    );

    assign busy = mw_busy | wc_busy | ~in_ready;  // fetch holds a triangle

endmodule

//--- tb_xform_ref.svh
`ifndef TB_XFORM_REF_SVH
`define TB_XFORM_REF_SVH

// shadow of the transform table as the host wrote it
xform_pkg::xform_t shadow [`XF_TABLE_DEPTH];

// q16.16 product, low fraction bits dropped toward minus infinity
function automatic geom_pkg::fixed_t ref_mul(geom_pkg::fixed_t a, geom_pkg::fixed_t b);
    longint              full;
    logic signed [63:0]  shifted;
    full    = longint'(a) * longint'(b);
    shifted = full >>> `XF_FRAC_BITS;
    return shifted[`XF_WORD_W-1:0];  // wraps
endfunction

function automatic geom_pkg::fixed_t ref_dot(geom_pkg::fixed_t a, geom_pkg::fixed_t b,
                                             geom_pkg::fixed_t c, geom_pkg::pos_t p);
    return ref_mul(a, p.x) + ref_mul(b, p.y) + ref_mul(c, p.z);
endfunction

function automatic geom_pkg::pos_t ref_rotate(geom_pkg::matrix_t m, geom_pkg::pos_t p);
    geom_pkg::pos_t r;
    r.x = ref_dot(m.r11, m.r12, m.r13, p);
    r.y = ref_dot(m.r21, m.r22, m.r23, p);
    r.z = ref_dot(m.r31, m.r32, m.r33, p);
    return r;
endfunction

// model space to world space to camera space
function automatic geom_pkg::vertex_t ref_vertex(geom_pkg::vertex_t v,
                                                 xform_pkg::xform_t mdl,
                                                 xform_pkg::xform_t cam);
    geom_pkg::pos_t    s;
    geom_pkg::pos_t    w;
    geom_pkg::pos_t    d;
    geom_pkg::vertex_t r;
    s.x = ref_mul(v.pos.x, mdl.scale.x);
    s.y = ref_mul(v.pos.y, mdl.scale.y);
    s.z = ref_mul(v.pos.z, mdl.scale.z);
    w   = ref_rotate(mdl.rot, s);
    d.x = w.x + mdl.pos.x - cam.pos.x;
    d.y = w.y + mdl.pos.y - cam.pos.y;
    d.z = w.z + mdl.pos.z - cam.pos.z;
    r.pos   = ref_rotate(cam.rot, d);
    r.color = v.color;  // untouched
    return r;
endfunction

function automatic geom_pkg::triangle_t ref_triangle(geom_pkg::triangle_t t,
                                                     logic [`XF_ID_W-1:0] mid,
                                                     logic [`XF_ID_W-1:0] cid);
    geom_pkg::triangle_t r;
    r.v0 = ref_vertex(t.v0, shadow[mid], shadow[cid]);
    r.v1 = ref_vertex(t.v1, shadow[mid], shadow[cid]);
    r.v2 = ref_vertex(t.v2, shadow[mid], shadow[cid]);
    return r;
endfunction

`endif

//--- tb_geometry_front.sv
`timescale 1ns/1ps
`include "xform_cfg.svh"

module tb_geometry_front;

    typedef logic [$bits(geom_pkg::triangle_t)-1:0] word_t;

    logic                clk;
    logic                rst;
    logic                tbl_we;
    logic [`XF_ID_W-1:0] tbl_addr;
    xform_pkg::xform_t   tbl_wdata;
    geom_pkg::triangle_t tri_in;
    logic [`XF_ID_W-1:0] model_id;
    logic [`XF_ID_W-1:0] camera_id;
    logic                in_valid;
    logic                in_ready;
    geom_pkg::triangle_t tri_out;
    logic                out_valid;
    logic                out_ready;
    logic                busy;

    // scoreboard
    geom_pkg::triangle_t exp_q [$];
    logic [`XF_ID_W-1:0] mid_q [$];
    logic [`XF_ID_W-1:0] cid_q [$];
    int                  use_cnt [`XF_TABLE_DEPTH];
    int                  rewrites;

    `include "tb_xform_ref.svh"

    geometry_front dut (
        .clk, .rst, .tbl_we, .tbl_addr, .tbl_wdata,
        .tri_in, .model_id, .camera_id, .in_valid, .in_ready,
        .tri_out, .out_valid, .out_ready, .busy
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped by timeout");
    endtask

    // ----------------------------------------
    // random stimulus

    function automatic int rand_centered(int unsigned span);
        return int'($urandom % span) - int'(span / 2);
    endfunction

    function automatic logic [`XF_ID_W-1:0] rand_id();
        logic [31:0] r;
        r = $urandom % `XF_TABLE_DEPTH;
        return r[`XF_ID_W-1:0];
    endfunction

    function automatic xform_pkg::xform_t random_record();
        xform_pkg::xform_t r;
        for (int i = 0; i < 3; i++) begin
            r.scale[i*32 +: 32] = rand_centered(32'd524288);  // within +-4.0
            r.pos[i*32 +: 32]   = $urandom;
        end
        for (int i = 0; i < 9; i++) begin
            r.rot[i*32 +: 32] = rand_centered(32'd262143);  // below 2.0
        end
        return r;
    endfunction

    function automatic xform_pkg::xform_t identity_record();
        xform_pkg::xform_t r;
        r         = '0;
        r.scale.x = 32'h0001_0000;
        r.scale.y = 32'h0001_0000;
        r.scale.z = 32'h0001_0000;
        r.rot.r11 = 32'h0001_0000;
        r.rot.r22 = 32'h0001_0000;
        r.rot.r33 = 32'h0001_0000;
        return r;
    endfunction

    function automatic geom_pkg::vertex_t random_vertex();
        geom_pkg::vertex_t v;
        v.pos.x = rand_centered(32'd134217728);  // +-1024.0
        v.pos.y = rand_centered(32'd134217728);
        v.pos.z = rand_centered(32'd134217728);
        v.color = 24'($urandom);
        return v;
    endfunction

    task automatic load_table(input bit identity);
        for (int a = 0; a < `XF_TABLE_DEPTH; a++) begin
            @(negedge clk);
            tbl_we    = 1'b1;
            tbl_addr  = a[`XF_ID_W-1:0];
            tbl_wdata = identity ? identity_record() : random_record();
            shadow[a] = tbl_wdata;
        end
        @(negedge clk);
        tbl_we = 1'b0;
    endtask

    // every expected triangle has left, so any further output is extra
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        check("no extra output", word_t'(1'b0), word_t'(out_valid));
        while (busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > 200) stop_on_timeout("the pipeline to drain");
            check("no extra output", word_t'(1'b0), word_t'(out_valid));
        end
    endtask

    // ----------------------------------------
    // traffic with scoreboard, back-pressure and host rewrites

    task automatic run_traffic(input int count, input bit identity, input bit writes,
                               input int ready_pct);
        int                  sent;
        int                  received;
        int                  cycles;
        bit                  accepted;
        bit                  hold_seen;
        geom_pkg::triangle_t held;
        logic [`XF_ID_W-1:0] wa;
        logic [`XF_ID_W-1:0] done_mid;
        logic [`XF_ID_W-1:0] done_cid;
        sent      = 0;
        received  = 0;
        cycles    = 0;
        accepted  = 1'b0;
        hold_seen = 1'b0;
        while (received < count) begin
            @(negedge clk);
            cycles++;
            if (cycles > count * 100 + 1000) stop_on_timeout("output triangles");
            if (hold_seen) begin  // stalled output must not move
                check("out_valid held", word_t'(1'b1), word_t'(out_valid));
                check("tri_out held", held, tri_out);
            end
            if (accepted) in_valid = 1'b0;
            accepted = 1'b0;
            if (!in_valid && sent < count && ($urandom % 4) != 0) begin
                tri_in.v0 = random_vertex();
                tri_in.v1 = random_vertex();
                tri_in.v2 = random_vertex();
                model_id  = rand_id();
                camera_id = rand_id();
                in_valid  = 1'b1;
            end
            out_ready = ($urandom % 100) < ready_pct;
            tbl_we    = 1'b0;
            wa        = rand_id();
            if (writes && ($urandom % 8) == 0 && use_cnt[wa] == 0
                && !(in_valid && (wa == model_id || wa == camera_id))) begin
                tbl_we     = 1'b1;
                tbl_addr   = wa;
                tbl_wdata  = random_record();
                shadow[wa] = tbl_wdata;
                rewrites++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output triangle appeared with nothing in flight");
                    $display("=== FAIL ===");
                    $fatal(1, "unexpected output");
                end
                check("busy with output", word_t'(1'b1), word_t'(busy));
                check("tri_out", exp_q.pop_front(), tri_out);
                done_mid = mid_q.pop_front();
                done_cid = cid_q.pop_front();
                use_cnt[done_mid]--;
                use_cnt[done_cid]--;
                received++;
            end
            hold_seen = out_valid && !out_ready;
            held      = tri_out;
            if (in_valid && in_ready) begin  // transfer on the next rising edge
                exp_q.push_back(identity ? tri_in : ref_triangle(tri_in, model_id, camera_id));
                mid_q.push_back(model_id);
                cid_q.push_back(camera_id);
                use_cnt[model_id]++;
                use_cnt[camera_id]++;
                sent++;
                accepted = 1'b1;
            end
        end
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        tbl_we    = 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        tbl_we    = 1'b0;
        tbl_addr  = '0;
        tbl_wdata = '0;
        tri_in    = '0;
        model_id  = '0;
        camera_id = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        rewrites  = 0;
        for (int i = 0; i < `XF_TABLE_DEPTH; i++) begin
            use_cnt[i] = 0;
            shadow[i]  = '0;
        end
        void'($urandom(36));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check("reset in_ready", word_t'(1'b1), word_t'(in_ready));
        check("reset out_valid", word_t'(1'b0), word_t'(out_valid));
        check("reset busy", word_t'(1'b0), word_t'(busy));

        // identity transforms pass triangles straight through
        load_table(1'b1);
        run_traffic(20, 1'b1, 1'b0, 100);
        wait_idle();

        load_table(1'b0);
        run_traffic(200, 1'b0, 1'b1, 70);
        wait_idle();

        if (rewrites == 0) begin
            $display("no host write landed during traffic");
            $display("=== FAIL ===");
            $fatal(1, "host write path not exercised");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- list.f
+incdir+.
geom_pkg.sv
xform_pkg.sv
transform_table.sv
xform_table_arbiter.sv
model_fetch.sv
model_world_transformer.sv
world_camera_transformer.sv
geometry_front.sv
tb_geometry_front.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the geometry front testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_geometry_front \
    -o sim_tb && ./obj_dir/sim_tb || exit 1
